// File: design/xbar_pkg.sv
package xbar_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;      // One strobe bit per byte

    localparam int NUM_TARGETS_DEF = 3;

    // Target 0 instruction TCM, 1 data TCM, 2 peripheral window
    localparam logic [ADDR_W-1:0] TARGET_BASE [NUM_TARGETS_DEF] = '{
        32'h0000_0000,
        32'h1000_0000,
        32'h2000_0000
    };

    // Upper bits compared against the base
    localparam logic [ADDR_W-1:0] TARGET_MASK [NUM_TARGETS_DEF] = '{
        32'hffff_f000,                       // 4 KiB
        32'hffff_0000,                       // 64 KiB
        32'hffff_f000                        // 4 KiB
    };

    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY = 2'b00;

    // Shared by AR and AW
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        prot;
    } addr_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wdata_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        resp_t             resp;
    } rdata_t;

    typedef struct packed {
        resp_t resp;
    } bresp_t;

endpackage

// File: design/route_if.sv
`timescale 1ns/1ps

// Link between a route tracker and the router it steers
interface route_if #(
    parameter int NUM_TARGETS = xbar_pkg::NUM_TARGETS_DEF
);

    logic [NUM_TARGETS-1:0] start_tgt;       // Address accepted toward this target
    logic                   done;            // Closing handshake of the channel
    logic [NUM_TARGETS-1:0] sel;             // Registered owner of the channel
    logic                   busy;            // At least one open transaction
    logic [NUM_TARGETS-1:0] block;           // New start toward this target not allowed

    // Done comes from the response side and is tied in at the top level
    modport router (
        output start_tgt,
        input  block
    );

    modport tracker (
        input  start_tgt,
        input  done,
        output sel,
        output busy,
        output block
    );

endinterface

// File: design/addr_decoder.sv
`timescale 1ns/1ps

// Address to one-hot target match against the package map
module addr_decoder #(
    parameter int NUM_TARGETS = xbar_pkg::NUM_TARGETS_DEF
) (
    input  logic [xbar_pkg::ADDR_W-1:0] addr,
    output logic [NUM_TARGETS-1:0]      match
);

    logic [xbar_pkg::ADDR_W-1:0] masked [NUM_TARGETS];

    // Windows do not overlap, so at most one bit is set
    // An unmapped address gives all zeros and is never forwarded
    always_comb begin
        for (int i = 0; i < NUM_TARGETS; i++) begin
            masked[i] = addr & xbar_pkg::TARGET_MASK[i];
            match[i]  = (masked[i] == xbar_pkg::TARGET_BASE[i]);
        end
    end

endmodule

// File: design/route_tracker.sv
`timescale 1ns/1ps

// Outstanding transfers per target and the registered channel owner
module route_tracker #(
    parameter int NUM_TARGETS = xbar_pkg::NUM_TARGETS_DEF,
    parameter int CNT_W       = 3
) (
    input  logic  clk,
    input  logic  rst_n,
    route_if.tracker rif
);

    logic [CNT_W-1:0]       cnt     [NUM_TARGETS];
    logic [CNT_W-1:0]       cnt_nxt [NUM_TARGETS];
    logic [NUM_TARGETS-1:0] active;
    logic [NUM_TARGETS-1:0] active_nxt;
    logic [NUM_TARGETS-1:0] full;
    logic [NUM_TARGETS-1:0] done_tgt;
    logic [NUM_TARGETS-1:0] sel_q;

    // While busy the response belongs to sel
    // Otherwise it can only close a transfer started in the same cycle
    assign done_tgt = rif.busy ? (sel_q & {NUM_TARGETS{rif.done}})
                               : (rif.start_tgt & {NUM_TARGETS{rif.done}});

    always_comb begin
        for (int i = 0; i < NUM_TARGETS; i++) begin
            cnt_nxt[i]    = cnt[i] + CNT_W'(rif.start_tgt[i]) - CNT_W'(done_tgt[i]);
            active_nxt[i] = (cnt_nxt[i] != '0);
            active[i]     = (cnt[i] != '0);
            full[i]       = &cnt[i];
        end
    end

    for (genvar i = 0; i < NUM_TARGETS; i++) begin : gen_cnt
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cnt[i] <= '0;
            end else begin
                cnt[i] <= cnt_nxt[i];
            end
        end
    end

    // Owner follows the single active target, hold if several
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (active_nxt == '0) begin
            sel_q <= '0;
        end else if ($onehot(active_nxt)) begin
            sel_q <= active_nxt;
        end
    end

    assign rif.sel  = sel_q;
    assign rif.busy = |active;

    // A second target may only start once the current one has drained,
    // so responses come back in issue order
    assign rif.block = (rif.busy ? ~sel_q : '0) | full;

endmodule

// File: design/req_router.sv
`timescale 1ns/1ps

// Forwards one request channel to the decoded target
module req_router #(
    parameter int  NUM_TARGETS = xbar_pkg::NUM_TARGETS_DEF,
    parameter type payload_t   = xbar_pkg::addr_req_t
) (
    input  logic                   in_valid,
    input  payload_t               in_payload,
    input  logic [NUM_TARGETS-1:0] match,
    input  logic [NUM_TARGETS-1:0] tgt_ready,
    output logic                   in_ready,
    output logic [NUM_TARGETS-1:0] tgt_valid,
    output payload_t               tgt_payload,
    route_if.router                rif
);

    logic [NUM_TARGETS-1:0] grant;
    logic [NUM_TARGETS-1:0] accept;

    // Blocked or unmapped requests stay invisible to every target
    assign grant = match & ~rif.block;

    assign tgt_valid = grant & {NUM_TARGETS{in_valid}};
    assign accept    = tgt_valid & tgt_ready;

    // Ready only from the target that actually sees the request
    assign in_ready = |accept;

    // Request bus is shared, valid alone picks the target
    assign tgt_payload = in_payload;

    assign rif.start_tgt = accept;   // One-hot, one cycle per handshake

endmodule

// File: design/resp_mux.sv
`timescale 1ns/1ps

// Steers one handshake channel between the initiator and the owning target
module resp_mux #(
    parameter int  NUM_TARGETS = xbar_pkg::NUM_TARGETS_DEF,
    parameter type payload_t   = xbar_pkg::rdata_t
) (
    input  logic [NUM_TARGETS-1:0] sel,
    input  logic                   busy,
    input  logic [NUM_TARGETS-1:0] fallback_sel,
    input  logic [NUM_TARGETS-1:0] tgt_valid,
    input  payload_t               tgt_payload [NUM_TARGETS],
    input  logic                   out_ready,
    output logic [NUM_TARGETS-1:0] tgt_ready,
    output logic                   out_valid,
    output payload_t               out_payload,
    output logic                   done
);

    logic [NUM_TARGETS-1:0] route;

    // Registered owner while open, live decode when idle
    assign route = busy ? sel : fallback_sel;

    assign out_valid = |(route & tgt_valid);
    assign tgt_ready = route & {NUM_TARGETS{out_ready}};

    always_comb begin
        out_payload = '0;
        for (int i = 0; i < NUM_TARGETS; i++) begin
            if (route[i]) begin
                out_payload = tgt_payload[i];
            end
        end
    end

    assign done = out_valid & out_ready;

endmodule

// File: design/axi_lite_xbar.sv
`timescale 1ns/1ps

// One initiator, NUM_TARGETS AXI-Lite targets, fully combinational datapath
module axi_lite_xbar #(
    parameter int NUM_TARGETS = xbar_pkg::NUM_TARGETS_DEF,
    parameter int CNT_W       = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Initiator side
    input  logic                        ar_valid,
    output logic                        ar_ready,
    input  logic [xbar_pkg::ADDR_W-1:0] ar_addr,
    input  logic [2:0]                  ar_prot,
    output logic                        r_valid,
    input  logic                        r_ready,
    output logic [xbar_pkg::DATA_W-1:0] r_data,
    output xbar_pkg::resp_t             r_resp,
    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  logic [xbar_pkg::ADDR_W-1:0] aw_addr,
    input  logic [2:0]                  aw_prot,
    input  logic                        w_valid,
    output logic                        w_ready,
    input  logic [xbar_pkg::DATA_W-1:0] w_data,
    input  logic [xbar_pkg::STRB_W-1:0] w_strb,
    output logic                        b_valid,
    input  logic                        b_ready,
    output xbar_pkg::resp_t             b_resp,

    // Target side
    output logic [NUM_TARGETS-1:0]      t_ar_valid,
    input  logic [NUM_TARGETS-1:0]      t_ar_ready,
    output logic [xbar_pkg::ADDR_W-1:0] t_ar_addr,
    output logic [2:0]                  t_ar_prot,
    input  logic [NUM_TARGETS-1:0]      t_r_valid,
    output logic [NUM_TARGETS-1:0]      t_r_ready,
    input  logic [xbar_pkg::DATA_W-1:0] t_r_data [NUM_TARGETS],
    input  xbar_pkg::resp_t             t_r_resp [NUM_TARGETS],
    output logic [NUM_TARGETS-1:0]      t_aw_valid,
    input  logic [NUM_TARGETS-1:0]      t_aw_ready,
    output logic [xbar_pkg::ADDR_W-1:0] t_aw_addr,
    output logic [2:0]                  t_aw_prot,
    output logic [NUM_TARGETS-1:0]      t_w_valid,
    input  logic [NUM_TARGETS-1:0]      t_w_ready,
    output logic [xbar_pkg::DATA_W-1:0] t_w_data,
    output logic [xbar_pkg::STRB_W-1:0] t_w_strb,
    input  logic [NUM_TARGETS-1:0]      t_b_valid,
    output logic [NUM_TARGETS-1:0]      t_b_ready,
    input  xbar_pkg::resp_t             t_b_resp [NUM_TARGETS]
);

    logic [NUM_TARGETS-1:0] ar_match;
    logic [NUM_TARGETS-1:0] aw_match;
    logic [NUM_TARGETS-1:0] aw_free;

    xbar_pkg::addr_req_t ar_req;
    xbar_pkg::addr_req_t aw_req;
    xbar_pkg::addr_req_t t_ar_req;
    xbar_pkg::addr_req_t t_aw_req;

    xbar_pkg::rdata_t r_tgt [NUM_TARGETS];
    xbar_pkg::rdata_t r_out;
    xbar_pkg::wdata_t w_in  [NUM_TARGETS];
    xbar_pkg::wdata_t w_out;
    xbar_pkg::bresp_t b_tgt [NUM_TARGETS];
    xbar_pkg::bresp_t b_out;

    logic r_done;
    logic w_done;
    logic b_done;

    route_if #(.NUM_TARGETS(NUM_TARGETS)) rif_r ();
    route_if #(.NUM_TARGETS(NUM_TARGETS)) rif_w ();
    route_if #(.NUM_TARGETS(NUM_TARGETS)) rif_b ();

    assign ar_req   = '{addr: ar_addr, prot: ar_prot};
    assign aw_req   = '{addr: aw_addr, prot: aw_prot};
    assign t_ar_addr = t_ar_req.addr;
    assign t_ar_prot = t_ar_req.prot;
    assign t_aw_addr = t_aw_req.addr;
    assign t_aw_prot = t_aw_req.prot;

    for (genvar i = 0; i < NUM_TARGETS; i++) begin : gen_pack
        assign r_tgt[i] = '{data: t_r_data[i], resp: t_r_resp[i]};
        assign b_tgt[i] = '{resp: t_b_resp[i]};
        assign w_in[i]  = '{data: w_data, strb: w_strb};     // Same beat offered to all
    end

    assign r_data   = r_out.data;
    assign r_resp   = r_out.resp;
    assign b_resp   = b_out.resp;
    assign t_w_data = w_out.data;
    assign t_w_strb = w_out.strb;

    // Closing events back into the trackers
    assign rif_r.done = r_done;
    assign rif_w.done = w_done;
    assign rif_b.done = b_done;

    // Both write trackers open on the same AW handshake
    assign rif_b.start_tgt = rif_w.start_tgt;

    // Response ordering also holds back AW, on top of the W tracker block
    assign aw_free = aw_match & ~rif_b.block;

    addr_decoder #(.NUM_TARGETS(NUM_TARGETS)) u_ar_dec (
        .addr  (ar_addr),
        .match (ar_match)
    );

    addr_decoder #(.NUM_TARGETS(NUM_TARGETS)) u_aw_dec (
        .addr  (aw_addr),
        .match (aw_match)
    );

    route_tracker #(.NUM_TARGETS(NUM_TARGETS), .CNT_W(CNT_W)) u_r_trk (
        .clk   (clk),
        .rst_n (rst_n),
        .rif   (rif_r)
    );

    route_tracker #(.NUM_TARGETS(NUM_TARGETS), .CNT_W(CNT_W)) u_w_trk (
        .clk   (clk),
        .rst_n (rst_n),
        .rif   (rif_w)
    );

    route_tracker #(.NUM_TARGETS(NUM_TARGETS), .CNT_W(CNT_W)) u_b_trk (
        .clk   (clk),
        .rst_n (rst_n),
        .rif   (rif_b)
    );

    req_router #(.NUM_TARGETS(NUM_TARGETS), .payload_t(xbar_pkg::addr_req_t)) u_ar_rtr (
        .in_valid    (ar_valid),
        .in_payload  (ar_req),
        .match       (ar_match),
        .tgt_ready   (t_ar_ready),
        .in_ready    (ar_ready),
        .tgt_valid   (t_ar_valid),
        .tgt_payload (t_ar_req),
        .rif         (rif_r)
    );

    req_router #(.NUM_TARGETS(NUM_TARGETS), .payload_t(xbar_pkg::addr_req_t)) u_aw_rtr (
        .in_valid    (aw_valid),
        .in_payload  (aw_req),
        .match       (aw_free),
        .tgt_ready   (t_aw_ready),
        .in_ready    (aw_ready),
        .tgt_valid   (t_aw_valid),
        .tgt_payload (t_aw_req),
        .rif         (rif_w)
    );

    // When idle, R and B follow the address currently being forwarded
    resp_mux #(.NUM_TARGETS(NUM_TARGETS), .payload_t(xbar_pkg::rdata_t)) u_r_mux (
        .sel          (rif_r.sel),
        .busy         (rif_r.busy),
        .fallback_sel (t_ar_valid),
        .tgt_valid    (t_r_valid),
        .tgt_payload  (r_tgt),
        .out_ready    (r_ready),
        .tgt_ready    (t_r_ready),
        .out_valid    (r_valid),
        .out_payload  (r_out),
        .done         (r_done)
    );

    // W runs the other way, target ready in and initiator valid out.
    // Data ahead of its address goes to the AW target being forwarded,
    // and targets take a W beat no earlier than its AW.
    resp_mux #(.NUM_TARGETS(NUM_TARGETS), .payload_t(xbar_pkg::wdata_t)) u_w_mux (
        .sel          (rif_w.sel),
        .busy         (rif_w.busy),
        .fallback_sel (t_aw_valid),
        .tgt_valid    (t_w_ready),
        .tgt_payload  (w_in),
        .out_ready    (w_valid),
        .tgt_ready    (t_w_valid),
        .out_valid    (w_ready),
        .out_payload  (w_out),
        .done         (w_done)
    );

    resp_mux #(.NUM_TARGETS(NUM_TARGETS), .payload_t(xbar_pkg::bresp_t)) u_b_mux (
        .sel          (rif_b.sel),
        .busy         (rif_b.busy),
        .fallback_sel (t_aw_valid),
        .tgt_valid    (t_b_valid),
        .tgt_payload  (b_tgt),
        .out_ready    (b_ready),
        .tgt_ready    (t_b_ready),
        .out_valid    (b_valid),
        .out_payload  (b_out),
        .done         (b_done)
    );

endmodule

// File: test/tb_target.sv
`timescale 1ns/1ps

// Behavioral AXI-Lite target, one open read and one open write at a time
module tb_target #(
    parameter logic [31:0] BASE = 32'h0000_0000,
    parameter logic [31:0] MASK = 32'hffff_f000,
    parameter logic [31:0] SEED = 32'h0000_f777
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ar_valid,
    output logic        ar_ready,
    input  logic [31:0] ar_addr,
    output logic        r_valid,
    input  logic        r_ready,
    output logic [31:0] r_data,
    output logic [1:0]  r_resp,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  logic [31:0] aw_addr,
    input  logic        w_valid,
    output logic        w_ready,
    input  logic [31:0] w_data,
    input  logic [3:0]  w_strb,
    output logic        b_valid,
    input  logic        b_ready,
    output logic [1:0]  b_resp,
    output logic [31:0] errors
);

    logic [31:0] mem [64];
    logic [31:0] rnd;
    logic [31:0] wr_addr;
    logic        rd_busy;
    logic        aw_got;
    logic        w_got;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Same pattern as the testbench model
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    assign ar_ready = rnd[19] & ~rd_busy;            // Random ready delays
    assign aw_ready = rnd[20] & ~aw_got;
    assign w_ready  = rnd[21] & aw_got & ~w_got;     // Data only after its address
    assign r_resp   = xbar_pkg::RESP_OKAY;
    assign b_resp   = xbar_pkg::RESP_OKAY;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd     <= SEED;
            rd_busy <= 1'b0;
            r_valid <= 1'b0;
            r_data  <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_valid <= 1'b0;
            wr_addr <= '0;
            errors  <= '0;
            for (int i = 0; i < 64; i++) begin
                mem[i] <= fill_word(BASE + 32'(i) * 32'd4);
            end
        end else begin
            rnd <= lcg_next(rnd);
            if (ar_valid && ar_ready) begin
                if ((ar_addr & MASK) != BASE) begin
                    $display("Target %h received read address %h outside its window",
                             BASE, ar_addr);
                    errors <= errors + 32'd1;
                end
                rd_busy <= 1'b1;
                r_data  <= mem[ar_addr[7:2]];
            end
            if (rd_busy && !r_valid && rnd[22]) r_valid <= 1'b1;
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                rd_busy <= 1'b0;
            end
            if (aw_valid && aw_ready) begin
                if ((aw_addr & MASK) != BASE) begin
                    $display("Target %h received write address %h outside its window",
                             BASE, aw_addr);
                    errors <= errors + 32'd1;
                end
                aw_got  <= 1'b1;
                wr_addr <= aw_addr;
            end
            if (w_valid && w_ready) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_strb[b]) mem[wr_addr[7:2]][b*8 +: 8] <= w_data[b*8 +: 8];
                end
                w_got <= 1'b1;
            end
            if (w_got && !b_valid && rnd[23]) b_valid <= 1'b1;
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
                w_got   <= 1'b0;
                aw_got  <= 1'b0;
            end
        end
    end

endmodule

// File: test/tb_xbar.sv
`timescale 1ns/1ps

module tb_xbar;

    localparam int NT        = 3;
    localparam int NUM_TRANS = 200;
    localparam int LIMIT     = NUM_TRANS * 40 + 20;   // Cycles incl. reset

    logic        clk;
    logic        rst_n;
    logic        ar_valid, ar_ready, r_valid, r_ready;
    logic        aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic [31:0] ar_addr, aw_addr, w_data, r_data;
    logic [2:0]  ar_prot, aw_prot;
    logic [3:0]  w_strb;
    logic [1:0]  r_resp, b_resp;

    logic [NT-1:0] t_ar_valid, t_ar_ready, t_r_valid, t_r_ready, t_aw_valid, t_aw_ready;
    logic [NT-1:0] t_w_valid, t_w_ready, t_b_valid, t_b_ready;
    logic [31:0]   t_ar_addr, t_aw_addr, t_w_data;
    logic [2:0]    t_ar_prot, t_aw_prot;
    logic [3:0]    t_w_strb;
    logic [31:0]   t_r_data [NT];
    logic [1:0]    t_r_resp [NT];
    logic [1:0]    t_b_resp [NT];
    logic [31:0]   tgt_err  [NT];

    logic [31:0] model_mem [logic [31:0]];
    logic [31:0] rd_exp [$];                 // Read data in issue order
    logic [31:0] seed_state;
    int          errors;
    int          cycles;
    int          n_issued;
    int          n_resp;
    int          b_open;                     // Writes still waiting for B

    axi_lite_xbar #(.NUM_TARGETS(NT), .CNT_W(3)) dut0 (.*);

    for (genvar g = 0; g < NT; g++) begin : gen_tgt
        tb_target #(
            .BASE (xbar_pkg::TARGET_BASE[g]),
            .MASK (xbar_pkg::TARGET_MASK[g]),
            .SEED (32'hf777 ^ (32'(g) << 8))
        ) u_tgt (
            .clk(clk), .rst_n(rst_n),
            .ar_valid(t_ar_valid[g]), .ar_ready(t_ar_ready[g]), .ar_addr(t_ar_addr),
            .r_valid(t_r_valid[g]), .r_ready(t_r_ready[g]), .r_data(t_r_data[g]),
            .r_resp(t_r_resp[g]),
            .aw_valid(t_aw_valid[g]), .aw_ready(t_aw_ready[g]), .aw_addr(t_aw_addr),
            .w_valid(t_w_valid[g]), .w_ready(t_w_ready[g]), .w_data(t_w_data),
            .w_strb(t_w_strb),
            .b_valid(t_b_valid[g]), .b_ready(t_b_ready[g]), .b_resp(t_b_resp[g]),
            .errors(tgt_err[g])
        );
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] merge_strb(input logic [31:0] old, input logic [31:0] d,
                                               input logic [3:0] s);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) r[b*8 +: 8] = d[b*8 +: 8];
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic next_rand(output logic [31:0] v);
        seed_state = lcg_next(seed_state);
        v = seed_state;
    endtask

    task automatic check_idle_outputs();
        check_value("r_valid", 32'd0, 32'(r_valid));
        check_value("b_valid", 32'd0, 32'(b_valid));
        check_value("t_ar_valid", 32'd0, 32'(t_ar_valid));
        check_value("t_aw_valid", 32'd0, 32'(t_aw_valid));
        check_value("t_w_valid", 32'd0, 32'(t_w_valid));
        check_value("ar_ready", 32'd0, 32'(ar_ready));
        check_value("aw_ready", 32'd0, 32'(aw_ready));
        check_value("w_ready", 32'd0, 32'(w_ready));
    endtask

    // Address only, the R collector checks the data later
    task automatic issue_read(input logic [31:0] addr, input logic [2:0] prot);
        logic hs;
        ar_addr  = addr;
        ar_prot  = prot;
        ar_valid = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            #40 hs = ar_ready;                       // Sample just before the edge
            if (hs) begin
                check_value("t_ar_addr", addr, t_ar_addr);
                check_value("t_ar_prot", 32'(prot), 32'(t_ar_prot));
            end
            @(negedge clk);
        end
        ar_valid = 1'b0;
        n_issued++;
        rd_exp.push_back(model_mem.exists(addr) ? model_mem[addr] : fill_word(addr));
    endtask

    task automatic issue_write(input logic [31:0] addr, input logic [2:0] prot,
                               input logic [31:0] d, input logic [3:0] s);
        logic aw_done;
        logic w_done;
        aw_addr = addr;
        aw_prot = prot;
        w_data  = d;
        w_strb  = s;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!(aw_done && w_done)) begin
            aw_valid = !aw_done;
            w_valid  = !w_done;
            #40;
            if (aw_valid && aw_ready) begin
                aw_done = 1'b1;
                check_value("t_aw_addr", addr, t_aw_addr);
                check_value("t_aw_prot", 32'(prot), 32'(t_aw_prot));
            end
            if (w_valid && w_ready) w_done = 1'b1;
            @(negedge clk);
        end
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        n_issued++;
        b_open++;
        model_mem[addr] = merge_strb(model_mem.exists(addr) ? model_mem[addr] : fill_word(addr),
                                     d, s);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // R channel with random back-pressure, data checked in issue order
    initial begin
        logic [31:0] rnd;
        logic [31:0] exp_data;
        rnd     = 32'hf777 ^ 32'h0001_0000;
        r_ready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            rnd     = lcg_next(rnd);
            r_ready = rnd[20];
            #40;
            if (r_valid && r_ready) begin
                n_resp++;
                if (rd_exp.size() == 0) begin
                    errors++;
                    $display("Read response at %0t with no read outstanding", $time);
                end else begin
                    exp_data = rd_exp.pop_front();
                    check_value("r_data", exp_data, r_data);
                    check_value("r_resp", 32'(xbar_pkg::RESP_OKAY), 32'(r_resp));
                end
            end
        end
    end

    // B channel with random back-pressure
    initial begin
        logic [31:0] rnd;
        rnd     = 32'hf777 ^ 32'h0002_0000;
        b_ready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            rnd     = lcg_next(rnd);
            b_ready = rnd[21];
            #40;
            if (b_valid && b_ready) begin
                n_resp++;
                if (b_open == 0) begin
                    errors++;
                    $display("Write response at %0t with no write outstanding", $time);
                end else begin
                    b_open--;
                    check_value("b_resp", 32'(xbar_pkg::RESP_OKAY), 32'(b_resp));
                end
            end
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] addr;
        logic [2:0]  prot;
        int          total;
        rst_n = 1'b0;
        {ar_valid, aw_valid, w_valid} = '0;
        {ar_addr, aw_addr, w_data} = '0;
        {ar_prot, aw_prot, w_strb} = '0;
        seed_state = 32'hf777;
        errors   = 0;
        n_issued = 0;
        n_resp   = 0;
        b_open   = 0;
        repeat (10) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();                        // Idle right after reset
        // Next address goes out without waiting for the previous response
        for (int n = 0; n < NUM_TRANS; n++) begin
            next_rand(v);
            addr = xbar_pkg::TARGET_BASE[v[17:16] % 2'd3] + {24'd0, v[25:20], 2'b00};
            prot = v[10:8];
            if (v[28]) begin
                issue_read(addr, prot);
            end else begin
                next_rand(v);
                issue_write(addr, prot, v, seed_state[7:4]);
            end
        end
        while (rd_exp.size() != 0 || b_open != 0) begin
            @(negedge clk);
        end
        check_value("response count", 32'(n_issued), 32'(n_resp));
        total = errors + int'(tgt_err[0]) + int'(tgt_err[1]) + int'(tgt_err[2]);
        $display("Errors: %0d checks, %0d from targets", errors, total - errors);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
design/xbar_pkg.sv
design/route_if.sv
design/addr_decoder.sv
design/route_tracker.sv
design/req_router.sv
design/resp_mux.sv
design/axi_lite_xbar.sv
test/tb_target.sv
test/tb_xbar.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
verilator --binary --timing -f compile.f --top-module tb_xbar -o sim_xbar \
    && ./obj_dir/sim_xbar | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
